// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mini_core_tb
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== bench/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

typedef struct packed {
    logic [REG_AW-1:0]    addr;
    logic [WIDTH-1:0]     data;
    logic [NUM_FLAGS-1:0] flags;  // flags once the slot has retired
} exp_write_t;

exp_write_t           exp_q[$];
logic [WIDTH-1:0]     m_regs [NUM_REGS];
logic [WIDTH-1:0]     m_mem [2**MEM_AW];
logic                 m_stored [2**MEM_AW];
logic [NUM_FLAGS-1:0] m_flags;

function automatic void model_reset();
    for (int i = 0; i < NUM_REGS; i++)
        m_regs[i] = '0;
    for (int i = 0; i < 2**MEM_AW; i++) begin
        m_mem[i]    = '0;
        m_stored[i] = 1'b0;
    end
    m_flags = '0;
endfunction

function automatic void retire(input int rd, input logic [WIDTH-1:0] val);
    m_regs[rd] = val;
    exp_q.push_back({REG_AW'(rd), val, m_flags});
endfunction

// movh loads the high byte and movl the low byte
function automatic void model_long(input logic [31:0] w);
    int         code;
    logic [7:0] imm;
    code = int'(w[LCODE_HI:LCODE_LO]);
    imm  = w[IMM_HI:IMM_LO];
    if (code >= LONG_MOVH_BASE && code < LONG_MOVH_BASE + NUM_REGS)
        retire(code - LONG_MOVH_BASE, {imm, m_regs[code - LONG_MOVH_BASE][7:0]});
    else if (code >= LONG_MOVL_BASE && code < LONG_MOVL_BASE + NUM_REGS)
        retire(code - LONG_MOVL_BASE, {m_regs[code - LONG_MOVL_BASE][15:8], imm});
endfunction

// returns 1 when the slot changed the flags
function automatic logic model_short(input logic [15:0] h);
    logic [3:0]       opc;
    int               a;
    int               b;
    logic             ok;
    logic [WIDTH-1:0] x;
    logic [WIDTH-1:0] y;
    logic [WIDTH:0]   r;
    logic             v;
    opc = h[15:12];
    a   = int'(h[11:9]);
    b   = int'(h[8:6]);
    ok  = (a < NUM_REGS) && (b < NUM_REGS);
    x   = ok ? m_regs[a] : '0;
    y   = ok ? m_regs[b] : '0;
    v   = 1'b0;
    r   = '0;
    case (opc)
        4'd0: begin
            r = {1'b0, x} + {1'b0, y};
            v = (x[15] == y[15]) && (r[15] != x[15]);
        end
        4'd1: begin
            r = {x < y, x - y};  // carry is the borrow
            v = (x[15] != y[15]) && (r[15] != x[15]);
        end
        4'd2:    r = {1'b0, x & y};
        4'd3:    r = {1'b0, x | y};
        4'd4:    r = {1'b0, x ^ y};
        4'd5:    r = {1'b0, x << y[3:0]};
        4'd6:    r = {1'b0, x >> y[3:0]};
        default: r = '0;
    endcase
    model_short = 1'b0;
    if (opc < 4'd7) begin
        if (ok && h[5]) begin
            m_flags[FLAG_CARRY]    = r[WIDTH];
            m_flags[FLAG_SIGN]     = r[WIDTH-1];
            m_flags[FLAG_OVERFLOW] = v;
            m_flags[FLAG_ZERO]     = (r[WIDTH-1:0] == '0);
            model_short            = 1'b1;
        end
        if (ok)
            retire(a, r[WIDTH-1:0]);
    end else if (opc == 4'd7 && ok) begin
        retire(a, y);
    end else if (opc == 4'd8 && a < NUM_REGS) begin
        retire(a, WIDTH'(m_flags));
    end else if (opc == 4'd9 && ok) begin
        retire(a, m_mem[y[MEM_AW-1:0]]);
    end else if (opc == 4'd10 && ok) begin
        m_mem[y[MEM_AW-1:0]]    = x;
        m_stored[y[MEM_AW-1:0]] = 1'b1;
    end
endfunction

function automatic logic [REG_AW-1:0] pick_reg();
    logic [31:0] r;
    r = xorshift32();
    if (r[7:0] < 8'd10)
        pick_reg = REG_AW'(6 + int'(r[8]));  // illegal code now and then
    else
        pick_reg = REG_AW'(int'(r[15:8]) % NUM_REGS);
endfunction

function automatic logic [15:0] gen_half(input logic upper, input logic movf_ok);
    logic [31:0]       r;
    logic [3:0]        opc;
    logic [REG_AW-1:0] a;
    logic [REG_AW-1:0] b;
    int                idx;
    r   = xorshift32();
    a   = pick_reg();
    b   = pick_reg();
    opc = upper ? {1'b0, r[2:0]} : r[3:0];
    if (opc == MOVF && !movf_ok)
        opc = MOV;
    if (opc == LD) begin
        opc = ST;  // falls back to a store if nothing stored is reachable
        for (int k = 0; k < NUM_REGS; k++) begin
            idx = (k + int'(r[10:8])) % NUM_REGS;
            if (m_stored[m_regs[idx][MEM_AW-1:0]]) begin
                opc = LD;
                b   = REG_AW'(idx);
            end
        end
    end
    return {opc, a, b, r[16], r[21:17]};
endfunction

// one fetch word that the model has already executed
function automatic logic [31:0] gen_word();
    logic [31:0] r;
    logic [31:0] w;
    logic [15:0] hi;
    logic [15:0] lo;
    logic        hi_flags;
    r = xorshift32();
    if (r[1:0] == 2'b00) begin
        w = xorshift32();
        w[LONG_BIT] = 1'b1;
        if (r[7:4] != 4'd0)
            w[LCODE_HI:LCODE_LO] = 5'(LONG_MOVH_BASE + int'(r[12:8]) % 12);
        model_long(w);
    end else begin
        hi       = gen_half(1'b1, 1'b1);
        hi_flags = model_short(hi);
        // movf snapshots flags at decode before the upper slot updates them
        lo       = gen_half(1'b0, !hi_flags);
        void'(model_short(lo));
        w        = {hi, lo};
    end
    return w;
endfunction

`endif

// ==== bench/mini_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mini_core_tb
    import cpu_pkg::*;
();

    localparam int WIDTH         = 16;
    localparam int MEM_AW        = 4;
    localparam int NUM_WORDS     = 400;
    localparam int BUSY_TIMEOUT  = 20;
    localparam int DRAIN_TIMEOUT = 50;

    logic                 clk;
    logic                 arst_n;
    logic                 word_valid;
    logic [31:0]          word;
    logic                 busy;
    logic                 wr_en;
    logic [REG_AW-1:0]    wr_addr;
    logic [WIDTH-1:0]     wr_data;
    logic [NUM_FLAGS-1:0] flags;
    logic [31:0]          rng_state;
    logic                 flags_due = 1'b0;
    logic [NUM_FLAGS-1:0] flags_due_val;

    mini_core #(
        .WIDTH  (WIDTH),
        .MEM_AW (MEM_AW)
    ) i_mini_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .word_valid (word_valid),
        .word       (word),
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .flags      (flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    `include "core_model.svh"

    task automatic fail_and_stop();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_write(
        input logic [REG_AW-1:0] got_addr,
        input logic [REG_AW-1:0] exp_addr,
        input logic [WIDTH-1:0]  got_data,
        input logic [WIDTH-1:0]  exp_data
    );
        if (got_addr !== exp_addr) begin
            $display("mismatch wr_addr: got %h, expected %h", got_addr, exp_addr);
            fail_and_stop();
        end else if (got_data !== exp_data) begin
            $display("mismatch wr_data: got %h, expected %h", got_data, exp_data);
            fail_and_stop();
        end
    endtask

    task automatic check_flags(input logic [NUM_FLAGS-1:0] got, input logic [NUM_FLAGS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch flags: got %h, expected %h", got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch busy: got %h, expected %h", got, exp);
            fail_and_stop();
        end
    endtask

    // write-back is stable mid-cycle and flags settle one edge after the write
    always @(negedge clk) begin : write_monitor
        exp_write_t next_exp;
        if (arst_n) begin
            if (flags_due) begin
                check_flags(flags, flags_due_val);
                flags_due = 1'b0;
            end
            if (wr_en && exp_q.size() == 0) begin
                $display("unexpected register write to r%0d", wr_addr);
                fail_and_stop();
            end else if (wr_en) begin
                next_exp = exp_q.pop_front();
                check_write(wr_addr, next_exp.addr, wr_data, next_exp.data);
                flags_due     = 1'b1;
                flags_due_val = next_exp.flags;
            end
        end
    end

    task automatic send_word(input logic [31:0] w);
        int waited;
        waited = 0;
        while (busy && waited < BUSY_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            $display("timed out waiting for busy to drop");
            fail_and_stop();
        end else begin
            word       = w;
            word_valid = 1'b1;
            @(posedge clk);
            #1;
            word_valid = 1'b0;
            check_busy(busy, !w[LONG_BIT]);  // pair holds for its lower half
            if (!w[LONG_BIT]) begin
                @(posedge clk);
                #1;
                check_busy(busy, 1'b0);
            end
        end
    endtask

    initial begin
        int waited;
        rng_state  = 32'd64621;
        arst_n     = 1'b0;
        word_valid = 1'b0;
        word       = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_busy(busy, 1'b0);
        check_flags(flags, '0);
        repeat (3) @(posedge clk);  // idle cycles where any write is caught
        #1;
        for (int n = 0; n < NUM_WORDS; n++)
            send_word(gen_word());
        waited = 0;
        while ((exp_q.size() != 0 || flags_due) && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || flags_due) begin
            $display("timed out with %0d register writes still expected", exp_q.size());
            fail_and_stop();
        end else begin
            repeat (4) @(posedge clk);
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu
    import cpu_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  en,
    input  wire opcode_t         opcode,
    input  wire  [WIDTH-1:0]     a,
    input  wire  [WIDTH-1:0]     b,
    input  wire                  set_flags,
    output logic [WIDTH-1:0]     result,
    output logic [NUM_FLAGS-1:0] flags
);

    logic [WIDTH:0]          sum;
    logic [WIDTH:0]          diff;
    logic                    carry;
    logic                    ovf;
    logic [NUM_FLAGS-1:0]    nxt_flags;

    always_comb begin
        sum   = {1'b0, a} + {1'b0, b};
        diff  = {1'b0, a} - {1'b0, b};
        carry = 1'b0;
        ovf   = 1'b0;
        case (opcode)
            ADD: begin
                result = sum[WIDTH-1:0];
                carry  = sum[WIDTH];
                ovf    = (a[WIDTH-1] == b[WIDTH-1]) && (result[WIDTH-1] != a[WIDTH-1]);
            end
            SUB: begin
                result = diff[WIDTH-1:0];
                carry  = diff[WIDTH];  // borrow
                ovf    = (a[WIDTH-1] != b[WIDTH-1]) && (result[WIDTH-1] != a[WIDTH-1]);
            end
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SHL:     result = a << b[3:0];
            SHR:     result = a >> b[3:0];
            MOV:     result = b;
            default: result = '0;
        endcase

        nxt_flags                = '0;
        nxt_flags[FLAG_CARRY]    = carry;
        nxt_flags[FLAG_SIGN]     = result[WIDTH-1];
        nxt_flags[FLAG_OVERFLOW] = ovf;
        nxt_flags[FLAG_ZERO]     = (result == '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            flags <= '0;
        else if (en && set_flags)
            flags <= nxt_flags;  // only suffixed ops touch flags
    end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // opcodes 8 and up only fit the lower half
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SHL  = 4'd5,
        SHR  = 4'd6,
        MOV  = 4'd7,
        MOVF = 4'd8,
        LD   = 4'd9,
        ST   = 4'd10,
        NOP  = 4'd11
    } opcode_t;

    typedef enum logic [1:0] {
        MV_REG,
        MV_LOW,
        MV_HIGH,
        MV_FLAGS
    } mov_kind_t;

    localparam int REG_AW    = 3;
    localparam int NUM_REGS  = 6;  // codes 6 and 7 are illegal
    localparam int NUM_FLAGS = 4;

    localparam int FLAG_CARRY    = 0;
    localparam int FLAG_SIGN     = 1;
    localparam int FLAG_OVERFLOW = 2;
    localparam int FLAG_ZERO     = 3;

    // code in 13:9 of a long word picks movh or movl and the destination
    localparam int LONG_BIT       = 31;
    localparam int LCODE_HI       = 13;
    localparam int LCODE_LO       = 9;
    localparam int LONG_MOVH_BASE = 6;
    localparam int LONG_MOVL_BASE = 12;
    localparam int IMM_HI         = 23;
    localparam int IMM_LO         = 16;
    localparam int IMM_W          = IMM_HI - IMM_LO + 1;

    // fields inside one 16-bit half
    localparam int OPC_HI     = 15;
    localparam int OPC_LO     = 12;
    localparam int OP1_HI     = 11;
    localparam int OP1_LO     = 9;
    localparam int OP2_HI     = 8;
    localparam int OP2_LO     = 6;
    localparam int SUFFIX_BIT = 5;

endpackage

`default_nettype wire

// ==== design/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem #(
    parameter int WIDTH  = 16,
    parameter int MEM_AW = 4
) (
    input  wire               clk,
    input  wire  [MEM_AW-1:0] addr,
    input  wire               wr_en,
    input  wire  [WIDTH-1:0]  wr_data,
    output logic [WIDTH-1:0]  rd_data
);

    logic [WIDTH-1:0] mem [2**MEM_AW];

    assign rd_data = mem[addr];  // read in the execute cycle

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[addr] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
    import cpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  en,
    input  wire  [31:0]          long_instr,
    input  wire                  instr_choose,
    input  wire  [NUM_FLAGS-1:0] flags,
    output logic                 alu_en,
    output opcode_t              opcode,
    output logic                 mem_en,
    output logic                 wren,
    output logic                 move_en,
    output mov_kind_t            mov_kind,
    output logic [IMM_W-1:0]     immediate,
    output logic [REG_AW-1:0]    op1,
    output logic [REG_AW-1:0]    op2,
    output logic                 suffix,
    output logic [NUM_FLAGS-1:0] flags_snap
);

    logic [15:0]       half;
    logic [4:0]        lcode;
    logic              is_long;
    logic              regs_ok;
    opcode_t           d_opcode;
    logic              d_alu_en;
    logic              d_mem_en;
    logic              d_wren;
    logic              d_move_en;
    mov_kind_t         d_kind;
    logic [REG_AW-1:0] d_op1;
    logic [REG_AW-1:0] d_op2;

    assign half    = instr_choose ? long_instr[15:0] : long_instr[31:16];
    assign lcode   = long_instr[LCODE_HI:LCODE_LO];
    assign is_long = !instr_choose && long_instr[LONG_BIT];

    always_comb begin
        d_opcode  = opcode_t'(half[OPC_HI:OPC_LO]);
        d_op1     = half[OP1_HI:OP1_LO];
        d_op2     = half[OP2_HI:OP2_LO];
        d_alu_en  = 1'b0;
        d_mem_en  = 1'b0;
        d_wren    = 1'b0;
        d_move_en = 1'b0;
        d_kind    = MV_REG;
        regs_ok   = (d_op1 < NUM_REGS) && (d_op2 < NUM_REGS);
        if (is_long) begin
            d_opcode = NOP;
            if (lcode >= LONG_MOVH_BASE && lcode < LONG_MOVL_BASE) begin
                d_move_en = 1'b1;
                d_kind    = MV_HIGH;
                d_op1     = REG_AW'(lcode - LONG_MOVH_BASE);
            end else if (lcode >= LONG_MOVL_BASE && lcode < LONG_MOVL_BASE + NUM_REGS) begin
                d_move_en = 1'b1;
                d_kind    = MV_LOW;
                d_op1     = REG_AW'(lcode - LONG_MOVL_BASE);
            end
        end else begin
            case (d_opcode)
                ADD, SUB, AND, OR, XOR, SHL, SHR: d_alu_en = regs_ok;
                MOV: d_move_en = regs_ok;
                MOVF: begin
                    d_move_en = (d_op1 < NUM_REGS);  // op2 not used
                    d_kind    = MV_FLAGS;
                end
                LD: d_mem_en = regs_ok;
                ST: begin
                    d_mem_en = regs_ok;
                    d_wren   = regs_ok;
                end
                default: d_opcode = NOP;  // nop and spare codes
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_en  <= 1'b0;
            mem_en  <= 1'b0;
            wren    <= 1'b0;
            move_en <= 1'b0;
        end else begin
            alu_en  <= en && d_alu_en;
            mem_en  <= en && d_mem_en;
            wren    <= en && d_wren;
            move_en <= en && d_move_en;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            opcode    <= d_opcode;
            op1       <= d_op1;
            op2       <= d_op2;
            mov_kind  <= d_kind;
            immediate <= long_instr[IMM_HI:IMM_LO];
            suffix    <= d_alu_en && half[SUFFIX_BIT];
        end
        // flags as they stand at decode; a flag-setting slot one cycle
        // ahead has not reached the flags register yet
        if (en && d_kind == MV_FLAGS)
            flags_snap <= flags;
    end

    a_one_enable_class: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({alu_en, mem_en, move_en})
    ) else $error("more than one enable class in a slot");

endmodule

`default_nettype wire

// ==== design/mini_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module mini_core
    import cpu_pkg::*;
#(
    parameter int WIDTH  = 16,
    parameter int MEM_AW = 4
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  word_valid,
    input  wire  [31:0]          word,
    output logic                 busy,
    output logic                 wr_en,
    output logic [REG_AW-1:0]    wr_addr,
    output logic [WIDTH-1:0]     wr_data,
    output logic [NUM_FLAGS-1:0] flags
);

    logic                 en;
    logic [31:0]          long_instr;
    logic                 instr_choose;
    logic                 alu_en;
    opcode_t              opcode;
    logic                 mem_en;
    logic                 wren;
    logic                 move_en;
    mov_kind_t            mov_kind;
    logic [IMM_W-1:0]     immediate;
    logic [REG_AW-1:0]    op1;
    logic [REG_AW-1:0]    op2;
    logic                 suffix;
    logic [NUM_FLAGS-1:0] flags_snap;
    logic [WIDTH-1:0]     rd_a;
    logic [WIDTH-1:0]     rd_b;
    logic [WIDTH-1:0]     alu_result;
    logic [WIDTH-1:0]     mem_rd;

    word_sequencer i_word_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .word_valid   (word_valid),
        .word         (word),
        .busy         (busy),
        .en           (en),
        .long_instr   (long_instr),
        .instr_choose (instr_choose)
    );

    instr_decoder i_instr_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .long_instr   (long_instr),
        .instr_choose (instr_choose),
        .flags        (flags),
        .alu_en       (alu_en),
        .opcode       (opcode),
        .mem_en       (mem_en),
        .wren         (wren),
        .move_en      (move_en),
        .mov_kind     (mov_kind),
        .immediate    (immediate),
        .op1          (op1),
        .op2          (op2),
        .suffix       (suffix),
        .flags_snap   (flags_snap)
    );

    reg_file #(
        .WIDTH (WIDTH)
    ) i_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_a_addr (op1),
        .rd_a      (rd_a),
        .rd_b_addr (op2),
        .rd_b      (rd_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu #(
        .WIDTH (WIDTH)
    ) i_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (alu_en),
        .opcode    (opcode),
        .a         (rd_a),
        .b         (rd_b),
        .set_flags (suffix),
        .result    (alu_result),
        .flags     (flags)
    );

    // address from op2 register, store data from op1 register
    data_mem #(
        .WIDTH  (WIDTH),
        .MEM_AW (MEM_AW)
    ) i_data_mem (
        .clk     (clk),
        .addr    (rd_b[MEM_AW-1:0]),
        .wr_en   (mem_en && wren),
        .wr_data (rd_a),
        .rd_data (mem_rd)
    );

    // every writing slot targets op1, stores write nothing
    assign wr_en   = alu_en || move_en || (mem_en && !wren);
    assign wr_addr = op1;

    always_comb begin
        wr_data = alu_result;
        if (mem_en) begin
            wr_data = mem_rd;
        end else if (move_en) begin
            case (mov_kind)
                MV_LOW:   wr_data = {rd_a[WIDTH-1:IMM_W], immediate};
                MV_HIGH:  wr_data = {immediate, rd_a[WIDTH-IMM_W-1:0]};
                MV_FLAGS: wr_data = WIDTH'(flags_snap);  // zero-extended
                default:  wr_data = rd_b;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import cpu_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire  [REG_AW-1:0] rd_a_addr,
    output logic [WIDTH-1:0]  rd_a,
    input  wire  [REG_AW-1:0] rd_b_addr,
    output logic [WIDTH-1:0]  rd_b,
    input  wire               wr_en,
    input  wire  [REG_AW-1:0] wr_addr,
    input  wire  [WIDTH-1:0]  wr_data
);

    logic [WIDTH-1:0] regs [NUM_REGS];

    // codes 6 and 7 read as zero
    assign rd_a = (rd_a_addr < NUM_REGS) ? regs[rd_a_addr] : '0;
    assign rd_b = (rd_b_addr < NUM_REGS) ? regs[rd_b_addr] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr < NUM_REGS) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // decoder must have filtered illegal destinations
    a_wr_addr_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> (wr_addr < NUM_REGS)
    ) else $error("write to illegal register %0d", wr_addr);

endmodule

`default_nettype wire

// ==== design/word_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_sequencer
    import cpu_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire         word_valid,
    input  wire  [31:0] word,
    output logic        busy,
    output logic        en,
    output logic [31:0] long_instr,
    output logic        instr_choose
);

    typedef enum logic {
        IDLE,
        SECOND
    } seq_state_t;

    seq_state_t state;
    logic       accept;

    assign accept = word_valid && !busy;
    assign busy   = (state == SECOND);  // lower half still to issue

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            en           <= 1'b0;
            instr_choose <= 1'b0;
        end else begin
            en           <= accept || busy;
            instr_choose <= busy;  // second slot takes the lower half
            if (accept && !word[LONG_BIT])
                state <= SECOND;
            else
                state <= IDLE;
        end
    end

    // word kept for the lower slot of a pair
    always_ff @(posedge clk) begin
        if (accept)
            long_instr <= word;
    end

    a_no_valid_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        busy |-> !word_valid
    ) else $error("word_valid pulsed while busy");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
design/cpu_pkg.sv
design/word_sequencer.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/data_mem.sv
design/mini_core.sv
bench/mini_core_tb.sv
